/* Makefile */
# Verilator build of the min-heap testbench

SIM := obj_dir/Vtb_min_heap

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module tb_min_heap -f flist.f -Mdir obj_dir

run: compile
	./$(SIM)

clean:
	rm -rf obj_dir

/* flist.f */
+incdir+.
heap_pkg.sv
heap_root.sv
heap_level_mem.sv
heap_stage.sv
min_heap.sv
tb_min_heap.sv

/* heap_level_mem.sv */
/*
 * heap level memory
 * two banks (even and odd positions) for one heap level, shared by the
 * stage above and the stage of this level; one-cycle reads with
 * write bypass, banks cleared by a counter after reset
 */
`timescale 1ns/1ps

module heap_level_mem #(
   parameter int N_LEVELS = 4,
   parameter int LEVEL    = 1
) (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  upper_active,
   input  logic                  own_next_active,
   input  heap_pkg::pos_t        upper_raddr,
   input  heap_pkg::pos_t        own_raddr,
   input  heap_pkg::mem_wr_t     upper_wr,
   input  heap_pkg::mem_wr_t     own_wr,
   output heap_pkg::heap_entry_t rd_left,
   output heap_pkg::heap_entry_t rd_right,
   output heap_pkg::heap_entry_t rd_own
);
   import heap_pkg::*;

   localparam heap_entry_t INIT_ENTRY = '{
      active:   1'b0,
      capacity: cap_t'((2 ** (N_LEVELS - LEVEL)) - 1),
      prio:     '0,
      data:     '0
   };

   pos_t        raddr;
   mem_wr_t     wr;
   logic        wr_left;
   logic        wr_right;
   logic        odd_q;
   heap_entry_t left_q;
   heap_entry_t right_q;

   // tokens are two cycles apart, so only one of the two stages needs the port
   assign raddr    = own_next_active ? own_raddr : upper_raddr;
   assign wr       = upper_active ? upper_wr : own_wr;
   assign wr_left  = wr.en && !wr.addr[0];
   assign wr_right = wr.en && wr.addr[0];

   always_ff @(posedge clk) begin
      odd_q <= raddr[0];
   end

   assign rd_left  = left_q;
   assign rd_right = right_q;
   assign rd_own   = odd_q ? right_q : left_q;

   generate
      if (LEVEL == 1) begin : g_regs
         // a single sibling pair kept in flops
         heap_entry_t left_reg;
         heap_entry_t right_reg;

         always_ff @(posedge clk) begin
            if (!rstn) begin
               left_reg  <= INIT_ENTRY;
               right_reg <= INIT_ENTRY;
            end else begin
               if (wr_left)
                  left_reg <= wr.entry;
               if (wr_right)
                  right_reg <= wr.entry;
            end
         end

         always_ff @(posedge clk) begin
            left_q  <= wr_left ? wr.entry : left_reg;
            right_q <= wr_right ? wr.entry : right_reg;
         end
      end else begin : g_ram
         localparam int IW    = LEVEL - 1;
         localparam int DEPTH = 2 ** IW;

         heap_entry_t     bank_l [DEPTH];
         heap_entry_t     bank_r [DEPTH];
         logic [IW-1:0]   rd_idx;
         logic [IW-1:0]   wr_idx;
         logic [IW-1:0]   init_idx;
         logic            init_busy;

         assign rd_idx = raddr[IW:1];   // bit 0 picks the bank
         assign wr_idx = wr.addr[IW:1];

         always_ff @(posedge clk) begin
            if (!rstn) begin
               init_idx  <= '0;
               init_busy <= 1'b1;
            end else if (init_busy) begin
               init_idx <= init_idx + 1'b1;
               if (&init_idx)
                  init_busy <= 1'b0;
            end
         end

         always_ff @(posedge clk) begin
            if (init_busy) begin
               bank_l[init_idx] <= INIT_ENTRY;
               bank_r[init_idx] <= INIT_ENTRY;
            end else begin
               if (wr_left)
                  bank_l[wr_idx] <= wr.entry;
               if (wr_right)
                  bank_r[wr_idx] <= wr.entry;
            end
         end

         // same-cycle write to the read word wins
         always_ff @(posedge clk) begin
            if (wr_left && wr_idx == rd_idx)
               left_q <= wr.entry;
            else
               left_q <= bank_l[rd_idx];
            if (wr_right && wr_idx == rd_idx)
               right_q <= wr.entry;
            else
               right_q <= bank_r[rd_idx];
         end
      end
   endgenerate

endmodule

/* heap_pkg.sv */
/*
 * heap package
 * shared constants, op encoding and the entry, token and write-request
 * structs used by every level of the pipelined min-heap
 */
package heap_pkg;

   localparam int MAX_LEVELS = 8;   // sizes positions and capacities
   localparam int PRIO_W     = 16;
   localparam int DATA_W     = 16;

   // 1-based node position with children at 2p and 2p+1
   typedef logic [MAX_LEVELS-1:0] pos_t;

   // free slots in the subtree rooted at a node and including it
   typedef logic [MAX_LEVELS-1:0] cap_t;

   typedef enum logic [1:0] {
      NOP     = 2'd0,
      ENQ     = 2'd1,
      DEQ_MIN = 2'd2
   } heap_op_t;

   typedef struct packed {
      logic              active;
      cap_t              capacity;
      logic [PRIO_W-1:0] prio;
      logic [DATA_W-1:0] data;
   } heap_entry_t;

   // token handed from one sift stage to the next
   typedef struct packed {
      heap_op_t          op;
      pos_t              pos;
      logic [PRIO_W-1:0] prio;   // entry carried down by ENQ
      logic [DATA_W-1:0] data;
   } stage_token_t;

   typedef struct packed {
      logic        en;
      pos_t        addr;
      heap_entry_t entry;
   } mem_wr_t;

endpackage

/* heap_root.sv */
/*
 * heap root
 * holds the minimum entry, accepts external ops and builds the
 * level-0 token; ready drops while stage 0 works on a token
 */
`timescale 1ns/1ps

module heap_root #(
   parameter int N_LEVELS = 4
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  heap_pkg::heap_op_t            in_op,
   input  logic [heap_pkg::PRIO_W-1:0]   in_prio,
   input  logic [heap_pkg::DATA_W-1:0]   in_data,
   input  heap_pkg::mem_wr_t             stage_wr,
   input  logic                          stage_busy,
   output logic                          ready,
   output heap_pkg::heap_entry_t         root,
   output heap_pkg::stage_token_t        token
);
   import heap_pkg::*;

   // deepest level memory needs this many cycles to clear its banks
   localparam int INIT_CYCLES = 2 ** (N_LEVELS - 2);
   localparam cap_t ROOT_CAP = cap_t'((2 ** N_LEVELS) - 1);

   logic [N_LEVELS-2:0] init_cnt;
   logic                init_done;
   logic                accept;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         init_cnt  <= '0;
         init_done <= 1'b0;
      end else if (!init_done) begin
         init_cnt <= init_cnt + 1'b1;
         if (init_cnt == (N_LEVELS-1)'(INIT_CYCLES - 1))
            init_done <= 1'b1;
      end
   end

   assign ready  = init_done && !stage_busy;
   assign accept = ready && (in_op != NOP);

   // level-0 token that stage 0 captures on the accept edge
   always_comb begin
      token.op   = accept ? in_op : NOP;
      token.pos  = pos_t'(1);
      token.prio = in_prio;
      token.data = in_data;
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         root.active   <= 1'b0;
         root.capacity <= ROOT_CAP;
         root.prio     <= '0;
         root.data     <= '0;
      end else if (accept && in_op == DEQ_MIN && root.active) begin
         root.active   <= 1'b0;   // vacate now and let stage 0 refill next cycle
         root.capacity <= root.capacity + 1'b1;
      end else if (stage_wr.en) begin
         root <= stage_wr.entry;
      end
   end

endmodule

/* heap_stage.sv */
/*
 * heap sift stage
 * one per level; compares the registered token with its node and the
 * two children, issues the node and child writes and forms the token
 * for the next level
 */
`timescale 1ns/1ps

module heap_stage #(
   parameter int N_LEVELS = 4,
   parameter int LEVEL    = 0
) (
   input  logic                   clk,
   input  heap_pkg::stage_token_t token_in,
   input  heap_pkg::heap_entry_t  node,
   input  heap_pkg::heap_entry_t  left,
   input  heap_pkg::heap_entry_t  right,
   output heap_pkg::stage_token_t token_out,
   output logic                   busy,
   output heap_pkg::mem_wr_t      cur_wr,
   output heap_pkg::mem_wr_t      child_wr
);
   import heap_pkg::*;

   localparam bit LEAF = (LEVEL == N_LEVELS - 1);

   stage_token_t tok;
   stage_token_t next_tok;
   heap_entry_t  lift;
   logic         go_right;
   pos_t         child_pos;

   always_ff @(posedge clk) begin
      tok <= token_in;
   end

   assign busy = (tok.op != NOP);

   // smaller active child with ties going left
   assign go_right  = !left.active || (right.active && (right.prio < left.prio));
   assign lift      = go_right ? right : left;
   assign child_pos = {tok.pos[MAX_LEVELS-2:0], 1'b0};

   always_comb begin
      next_tok     = tok;
      next_tok.op  = NOP;
      next_tok.pos = child_pos;

      cur_wr.en    = 1'b0;
      cur_wr.addr  = tok.pos;
      cur_wr.entry = node;

      child_wr.en    = 1'b0;
      child_wr.addr  = {tok.pos[MAX_LEVELS-2:0], go_right};
      child_wr.entry = lift;

      case (tok.op)
         ENQ: begin
            cur_wr.en             = 1'b1;
            cur_wr.entry.capacity = node.capacity - 1'b1;   // one more slot used below
            if (!node.active) begin
               // the entry settles in an empty node
               cur_wr.entry.active = 1'b1;
               cur_wr.entry.prio   = tok.prio;
               cur_wr.entry.data   = tok.data;
            end else begin
               next_tok.op = ENQ;
               if (tok.prio < node.prio) begin
                  cur_wr.entry.prio = tok.prio;   // new entry stays and the old one sinks
                  cur_wr.entry.data = tok.data;
                  next_tok.prio     = node.prio;
                  next_tok.data     = node.data;
               end
               // go left while it has room and right otherwise
               next_tok.pos[0] = (left.capacity == '0);
            end
         end
         DEQ_MIN: begin
            if (left.active || right.active) begin
               cur_wr.en           = 1'b1;
               cur_wr.entry.active = 1'b1;
               cur_wr.entry.prio   = lift.prio;
               cur_wr.entry.data   = lift.data;

               child_wr.en                = !LEAF;
               child_wr.entry.active      = 1'b0;   // hole moves down
               child_wr.entry.capacity    = lift.capacity + 1'b1;

               next_tok.op     = DEQ_MIN;
               next_tok.pos[0] = go_right;
            end
         end
         default: begin
         end
      endcase

      // nothing lives below the leaf level
      if (LEAF)
         next_tok.op = NOP;
   end

   assign token_out = next_tok;

endmodule

/* min_heap.sv */
/*
 * pipelined min-heap priority queue
 * root register, one sift stage per level and a shared memory between
 * each pair of neighbouring stages
 */
`timescale 1ns/1ps

module min_heap #(
   parameter int N_LEVELS = 4
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  heap_pkg::heap_op_t            in_op,
   input  logic [heap_pkg::PRIO_W-1:0]   in_prio,
   input  logic [heap_pkg::DATA_W-1:0]   in_data,
   output logic                          ready,
   output logic                          out_valid,
   output logic [heap_pkg::PRIO_W-1:0]   out_prio,
   output logic [heap_pkg::DATA_W-1:0]   out_data,
   output heap_pkg::cap_t                capacity
);
   import heap_pkg::*;

   heap_entry_t         root_entry;
   stage_token_t        tok      [0:N_LEVELS];   // tok[l] enters stage l
   heap_entry_t         node     [0:N_LEVELS-1];
   heap_entry_t         kid_l    [0:N_LEVELS-1];
   heap_entry_t         kid_r    [0:N_LEVELS-1];
   mem_wr_t             cur_wr   [0:N_LEVELS-1];
   mem_wr_t             child_wr [0:N_LEVELS-1];
   logic [N_LEVELS-1:0] busy;

   heap_root #(
      .N_LEVELS (N_LEVELS)
   ) u_root (
      .clk        (clk),
      .rstn       (rstn),
      .in_op      (in_op),
      .in_prio    (in_prio),
      .in_data    (in_data),
      .stage_wr   (cur_wr[0]),
      .stage_busy (busy[0]),
      .ready      (ready),
      .root       (root_entry),
      .token      (tok[0])
   );

   assign node[0] = root_entry;

   // leaf stage children are inactive with no room
   assign kid_l[N_LEVELS-1] = '0;
   assign kid_r[N_LEVELS-1] = '0;

   for (genvar l = 0; l < N_LEVELS; l++) begin : g_stage
      heap_stage #(
         .N_LEVELS (N_LEVELS),
         .LEVEL    (l)
      ) u_stage (
         .clk       (clk),
         .token_in  (tok[l]),
         .node      (node[l]),
         .left      (kid_l[l]),
         .right     (kid_r[l]),
         .token_out (tok[l+1]),
         .busy      (busy[l]),
         .cur_wr    (cur_wr[l]),
         .child_wr  (child_wr[l])
      );
   end

   for (genvar l = 1; l < N_LEVELS; l++) begin : g_mem
      heap_level_mem #(
         .N_LEVELS (N_LEVELS),
         .LEVEL    (l)
      ) u_mem (
         .clk             (clk),
         .rstn            (rstn),
         .upper_active    (busy[l-1]),
         .own_next_active (tok[l].op != NOP),
         .upper_raddr     ({tok[l-1].pos[MAX_LEVELS-2:0], 1'b0}),
         .own_raddr       (tok[l].pos),
         .upper_wr        (child_wr[l-1]),
         .own_wr          (cur_wr[l]),
         .rd_left         (kid_l[l-1]),
         .rd_right        (kid_r[l-1]),
         .rd_own          (node[l])
      );
   end

   assign out_valid = root_entry.active;
   assign out_prio  = root_entry.prio;
   assign out_data  = root_entry.data;
   assign capacity  = root_entry.capacity;

endmodule

/* heap_tb_model.svh */
/*
 * min-heap reference model
 * sorted queue of live entries, expected root and capacity,
 * and the typed compare tasks used by the checking process
 */
`ifndef HEAP_TB_MODEL_SVH
`define HEAP_TB_MODEL_SVH

heap_entry_t ref_q[$];   // smallest priority first

function automatic void insert_sorted(input logic [PRIO_W-1:0] p, input logic [DATA_W-1:0] d);
   heap_entry_t e;
   int          i;
   e        = '0;
   e.active = 1'b1;
   e.prio   = p;
   e.data   = d;
   i        = 0;
   while (i < ref_q.size() && ref_q[i].prio < p)
      i++;
   ref_q.insert(i, e);
endfunction

// an empty queue stays empty on removal
function automatic void remove_min();
   if (ref_q.size() > 0)
      void'(ref_q.pop_front());
endfunction

function automatic int live_count();
   return ref_q.size();
endfunction

function automatic cap_t free_count();
   return cap_t'(SLOTS - ref_q.size());
endfunction

// expected root is the front of the sorted queue
function automatic heap_entry_t ref_root();
   heap_entry_t e;
   e          = '0;
   e.capacity = free_count();
   if (ref_q.size() > 0) begin
      e.active = 1'b1;
      e.prio   = ref_q[0].prio;
      e.data   = ref_q[0].data;
   end
   return e;
endfunction

task automatic check_entry(input heap_entry_t got, input heap_entry_t exp);
   logic bad;
   bad = (got.active !== exp.active);
   if (exp.active && (got.prio !== exp.prio || got.data !== exp.data))
      bad = 1'b1;   // prio and data only matter for a live root
   if (bad) begin
      $display("ERR %0t: root valid=%0b prio=%h data=%h, expected valid=%0b prio=%h data=%h",
               $time, got.active, got.prio, got.data, exp.active, exp.prio, exp.data);
      abort_run("root entry differs from the reference queue");
   end
endtask

task automatic check_cap(input cap_t got, input cap_t exp);
   if (got !== exp) begin
      $display("ERR %0t: capacity got %0d, expected %0d", $time, got, exp);
      abort_run("capacity differs from the reference queue");
   end
endtask

`endif

/* tb_min_heap.sv */
/*
 * testbench for the pipelined min-heap
 * drives ENQ and DEQ_MIN ops through the ready handshake and checks
 * the root outputs and capacity against a sorted reference queue
 */
`timescale 1ns/1ps

module tb_min_heap;
   import heap_pkg::*;

   localparam int N_LEVELS     = 4;
   localparam int SLOTS        = (2 ** N_LEVELS) - 1;
   localparam int N_RANDOM_OPS = 300;
   localparam int TOTAL_OPS    = 7 * 2 + 14 + 2 * SLOTS + 2 + N_RANDOM_OPS;
   localparam int CYCLE_LIMIT  = 4 * TOTAL_OPS + 64;

   logic                clk;
   logic                rstn;
   heap_op_t            in_op;
   logic [PRIO_W-1:0]   in_prio;
   logic [DATA_W-1:0]   in_data;
   logic                ready;
   logic                out_valid;
   logic [PRIO_W-1:0]   out_prio;
   logic [DATA_W-1:0]   out_data;
   cap_t                capacity;

   bit                  prio_used [0:(2 ** PRIO_W)-1];
   int                  cycles = 0;
   event                check_now;

   min_heap #(
      .N_LEVELS (N_LEVELS)
   ) uut (
      .clk       (clk),
      .rstn      (rstn),
      .in_op     (in_op),
      .in_prio   (in_prio),
      .in_data   (in_data),
      .ready     (ready),
      .out_valid (out_valid),
      .out_prio  (out_prio),
      .out_data  (out_data),
      .capacity  (capacity)
   );

   task automatic abort_run(input string why);
      $display("TESTS FAILED");
      $fatal(1, "%s", why);
   endtask

   `include "heap_tb_model.svh"

   initial clk = 1'b0;
   always #50 clk = ~clk;

   always @(posedge clk) begin
      cycles++;
      if (cycles >= CYCLE_LIMIT)
         abort_run("timeout, the heap stopped answering");
   end

   function automatic heap_entry_t observed_root();
      heap_entry_t e;
      e.active   = out_valid;
      e.capacity = capacity;
      e.prio     = out_prio;
      e.data     = out_data;
      return e;
   endfunction

   // checking process fired once per finished op
   always @(check_now) begin
      check_entry(observed_root(), ref_root());
      check_cap(capacity, free_count());
   end

   function automatic logic [PRIO_W-1:0] fresh_prio();
      logic [PRIO_W-1:0] p;
      do
         p = PRIO_W'($urandom());
      while (prio_used[p]);
      prio_used[p] = 1'b1;   // never handed out twice
      return p;
   endfunction

   // starts on a falling edge and returns on the falling edge where ready is back
   task automatic issue_op(input heap_op_t op, input logic [PRIO_W-1:0] p);
      logic [DATA_W-1:0] d;
      d = DATA_W'($urandom());
      while (!ready)
         @(negedge clk);
      in_op   = op;
      in_prio = p;
      in_data = d;
      @(negedge clk);
      in_op = NOP;
      if (op == ENQ)
         insert_sorted(p, d);
      else
         remove_min();
      if (ready)
         abort_run("ready stayed high in the cycle after an accepted op");
      @(negedge clk);
      if (!ready)
         abort_run("ready did not return one cycle after an accepted op");
      -> check_now;
   endtask

   task automatic enq_fixed(input int p);
      prio_used[PRIO_W'(p)] = 1'b1;
      issue_op(ENQ, PRIO_W'(p));
   endtask

   task automatic deq_min();
      issue_op(DEQ_MIN, PRIO_W'($urandom()));
   endtask

   initial begin
      void'($urandom(32'hb97351b1));
      rstn    = 1'b0;
      in_op   = NOP;
      in_prio = '0;
      in_data = '0;
      repeat (2) @(negedge clk);
      rstn = 1'b1;

      // empty heap once the level memories are cleared
      while (!ready)
         @(negedge clk);
      -> check_now;

      for (int i = 0; i < 7; i++)
         enq_fixed(4096 + 256 * i);   // rising order keeps the first at the root
      for (int i = 0; i < 7; i++)
         enq_fixed(3840 - 256 * i);   // falling order makes each one the new root
      repeat (14) deq_min();

      // fill and drain
      repeat (SLOTS) issue_op(ENQ, fresh_prio());
      repeat (SLOTS) deq_min();

      repeat (2) deq_min();   // nothing to remove

      for (int n = 0; n < N_RANDOM_OPS; n++) begin
         if (live_count() < SLOTS && ($urandom() & 1) == 0)
            issue_op(ENQ, fresh_prio());
         else
            deq_min();
      end

      @(negedge clk);
      $display("TESTS PASSED");
      $finish;
   end

endmodule
